// ==== tb/daq_input.txt ====
// line 1: Phase_in period in clocks (hex, 0x12c = 300)
// then one sample per line: ch0 ch1 ch2 ch3 (hex words)
012c
1234 a5f0 0001 7fff
0f3c 5a5a 8000 ffff
2468 b1c2 00ff 7e01
3579 c3d4 0100 6d02
468a d5e6 0201 5c03
579b e7f8 0302 4b04
68ac f90a 0403 3a05
79bd 0b1c 0504 2906
8ace 1d2e 0605 1807
9bdf 2f30 0706 0708
acf0 3142 0807 f609
bd01 4354 0908 e50a
ce12 5566 0a09 d40b
df23 6778 0b0a c30c
e034 798a 0c0b b20d
f145 8b9c 0d0c a10e

// ==== daq_capture.f ====
hdl/daq_pkg.sv
hdl/sample_fifo.sv
hdl/phase_meter.sv
hdl/conv_timer.sv
hdl/ad7606_reader.sv
hdl/wb_regs.sv
hdl/daq_top.sv
tb/ad7606_model.sv
tb/daq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and search the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module daq_tb -f daq_capture.f > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vdaq_tb > sim.log 2>&1 || echo "simulator returned an error status"
grep -q '^>>> PASS$' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb/daq_tb.sv ====
`timescale 1ns/1ps

module daq_tb;
    import daq_pkg::*;

    localparam int ACK_LIMIT = 20;
    localparam int POLL_LIMIT = 20000;
    localparam int N_SAMPLES = 16;
    localparam wb_data_t EMPTY_BITS = wb_data_t'(((1 << N_CH) - 1) << ST_EMPTY_LSB);
    localparam wb_data_t FULL_BIT = wb_data_t'(1 << ST_FULL);
    localparam wb_data_t ACTIVE_BIT = wb_data_t'(1 << ST_ACTIVE);
    localparam wb_data_t PHASE_ERR_BIT = wb_data_t'(1 << ST_PHASE_ERR);
    localparam wb_data_t RUN_MASK = EMPTY_BITS | FULL_BIT | ACTIVE_BIT;

    logic AD_CLK_40M;
    logic rst_n;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic wb_ack;
    adc_word_t adc_db;
    logic adc_busy;
    logic adc_convst_n;
    logic adc_cs_n;
    logic adc_rd_n;
    logic phase;
    logic phase_run;
    int phase_cnt;
    int cycle_cnt = 0;
    adc_word_t file_words [0:N_CH*N_SAMPLES];   // period, then samples
    period_t phase_period;

    daq_top u_daq_top (
        .AD_CLK_40M     (AD_CLK_40M),
        .rst_n_i        (rst_n),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat_w),
        .wb_dat_o       (wb_dat_r),
        .wb_ack_o       (wb_ack),
        .adc_db_i       (adc_db),
        .adc_busy_i     (adc_busy),
        .adc_convst_n_o (adc_convst_n),
        .adc_cs_n_o     (adc_cs_n),
        .adc_rd_n_o     (adc_rd_n),
        .phase_i        (phase)
    );

    ad7606_model u_ad7606_model (
        .AD_CLK_40M (AD_CLK_40M),
        .convst_n_i (adc_convst_n),
        .cs_n_i     (adc_cs_n),
        .rd_n_i     (adc_rd_n),
        .busy_o     (adc_busy),
        .db_o       (adc_db)
    );

    // --------------------
    // clock, cycle count, key phase
    initial AD_CLK_40M = 1'b0;
    always #50 AD_CLK_40M = ~AD_CLK_40M;

    always @(posedge AD_CLK_40M) cycle_cnt <= cycle_cnt + 1;

    always begin
        @(posedge AD_CLK_40M);
        #1;
        if (phase_run) begin
            phase_cnt++;
            if (phase_cnt == int'(phase_period) / 2) begin   // half period high, half low
                phase_cnt = 0;
                phase = ~phase;
            end
        end
    end

    // --------------------
    // checks and bus access
    function automatic adc_word_t expected_word(int smp, int ch);
        return file_words[1 + smp * N_CH + ch];
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input wb_data_t got, input wb_data_t exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("Mismatch at time %0t: %s read %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_period(input period_t got, input period_t exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("Mismatch at time %0t: %s read %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                             output wb_data_t rdat);
        int n;
        logic got_ack;
        @(posedge AD_CLK_40M);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdat;
        n = 0;
        got_ack = 1'b0;
        while (!got_ack && n < ACK_LIMIT) begin
            @(posedge AD_CLK_40M);
            #1;
            n++;
            got_ack = wb_ack;
        end
        rdat = wb_dat_r;                        // valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        if (!got_ack) begin
            fail_stop($sformatf("no Wishbone ack within %0d cycles at address %0d",
                                ACK_LIMIT, adr));
        end
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic read_period(output period_t p);
        wb_data_t lo;
        wb_data_t hi;
        wb_read(REG_PHASE_LO, lo);
        wb_read(REG_PHASE_HI, hi);
        p = {hi, lo};
    endtask

    task automatic wait_full();
        wb_data_t st;
        int start;
        start = cycle_cnt;
        st = '0;
        while (!st[ST_FULL] && cycle_cnt - start < POLL_LIMIT) begin
            wb_read(REG_STATUS, st);
        end
        if (!st[ST_FULL]) begin
            fail_stop("the sample FIFOs did not fill within the polling limit");
        end
        wb_read(REG_STATUS, st);                // active clears one cycle after full
        check_word(st & RUN_MASK, FULL_BIT, "status at end of run");
    endtask

    task automatic drain_run();
        wb_data_t got;
        for (int s = 0; s < N_SAMPLES; s++) begin
            for (int c = 0; c < N_CH; c++) begin
                wb_read(wb_addr_t'(REG_CH0 + c), got);
                check_word(got, expected_word(s, c),
                           $sformatf("channel %0d sample %0d", c, s));
            end
        end
        wb_read(REG_STATUS, got);
        check_word(got & RUN_MASK, EMPTY_BITS, "status after draining");
    endtask

    // --------------------
    // check sequence
    initial begin
        wb_data_t rd;
        period_t per;
        $readmemh("tb/daq_input.txt", file_words);
        phase_period = period_t'(file_words[0]);
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        phase = 1'b0;
        phase_cnt = 0;
        phase_run = 1'b1;
        repeat (4) @(posedge AD_CLK_40M);
        #1;
        rst_n = 1'b1;

        wb_read(REG_VERSION, rd);
        check_word(rd, VERSION_ID, "version");
        wb_read(REG_CONV_PERIOD, rd);
        check_word(rd, wb_data_t'(CONV_PERIOD_RST), "conversion period after reset");
        wb_read(REG_STATUS, rd);
        check_word(rd & RUN_MASK, EMPTY_BITS, "status after reset");

        wb_write(REG_CONV_PERIOD, 16'd120);     // well above one full read
        wb_read(REG_CONV_PERIOD, rd);
        check_word(rd, 16'd120, "conversion period");
        wb_write(REG_VERSION, 16'hbeef);
        wb_read(REG_VERSION, rd);
        check_word(rd, VERSION_ID, "version after write");

        repeat (4 * int'(phase_period)) @(posedge AD_CLK_40M);
        read_period(per);
        check_period(per, phase_period, "phase period");
        wb_read(REG_STATUS, rd);
        check_word(rd & PHASE_ERR_BIT, '0, "phase error bit while toggling");

        wb_write(REG_CTRL, 16'd1);
        wait_full();
        drain_run();
        wb_read(REG_CH0, rd);
        check_word(rd, '0, "read of an empty FIFO");

        wb_write(REG_CTRL, 16'd0);
        wb_write(REG_CTRL, 16'd1);              // second run from a fresh enable edge
        wait_full();
        drain_run();

        phase_run = 1'b0;
        repeat (PHASE_TIMEOUT + 2 * int'(phase_period)) @(posedge AD_CLK_40M);
        read_period(per);
        check_period(per, '0, "phase period after loss");
        wb_read(REG_STATUS, rd);
        check_word(rd & PHASE_ERR_BIT, PHASE_ERR_BIT, "phase error bit after loss");

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== tb/ad7606_model.sv ====
`timescale 1ns/1ps

module ad7606_model (
    input  logic               AD_CLK_40M,
    input  logic               convst_n_i,
    input  logic               cs_n_i,
    input  logic               rd_n_i,
    output logic               busy_o,
    output daq_pkg::adc_word_t db_o
);
    import daq_pkg::*;

    localparam int N_SAMPLES = 16;
    localparam int BUSY_DELAY = 2;     // cycles from convst rise to busy
    localparam int BUSY_CYCLES = 10;

    adc_word_t file_words [0:N_CH*N_SAMPLES];
    adc_sample_t samples [N_SAMPLES];
    logic convst_d;
    int smp;
    int ch;

    function automatic adc_word_t channel_word(adc_sample_t s, int c);
        case (c)
            0:       return s.ch0;
            1:       return s.ch1;
            2:       return s.ch2;
            default: return s.ch3;
        endcase
    endfunction

    initial begin
        $readmemh("tb/daq_input.txt", file_words);
        for (int i = 0; i < N_SAMPLES; i++) begin
            samples[i] = {file_words[1 + i * N_CH], file_words[2 + i * N_CH],
                          file_words[3 + i * N_CH], file_words[4 + i * N_CH]};
        end
        busy_o = 1'b0;
        db_o = '0;
        convst_d = 1'b1;
        smp = 0;
        ch = 0;
    end

    // --------------------
    // conversion timing
    always begin
        @(posedge AD_CLK_40M);
        #1;
        if (convst_n_i && !convst_d) begin
            repeat (BUSY_DELAY) @(posedge AD_CLK_40M);
            #1 busy_o = 1'b1;
            repeat (BUSY_CYCLES) @(posedge AD_CLK_40M);
            #1 busy_o = 1'b0;
        end
        convst_d = convst_n_i;
    end

    // next word on every read strobe, wraps after the last sample
    always @(negedge rd_n_i) begin
        #1;
        if (!cs_n_i) begin
            db_o = channel_word(samples[smp], ch);
            if (ch == N_CH - 1) begin
                ch = 0;
                smp = (smp + 1) % N_SAMPLES;
            end else begin
                ch++;
            end
        end
    end

endmodule

// ==== hdl/daq_top.sv ====
`timescale 1ns/1ps

module daq_top (
    input  logic              AD_CLK_40M,
    input  logic              rst_n_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  daq_pkg::wb_addr_t wb_adr_i,
    input  daq_pkg::wb_data_t wb_dat_i,
    output daq_pkg::wb_data_t wb_dat_o,
    output logic              wb_ack_o,
    input  daq_pkg::adc_word_t adc_db_i,
    input  logic              adc_busy_i,
    output logic              adc_convst_n_o,
    output logic              adc_cs_n_o,
    output logic              adc_rd_n_o,
    input  logic              phase_i
);
    import daq_pkg::*;

    wire adc_sample_t sample;
    wire adc_sample_t fifo_head;   // head word of every channel FIFO
    logic sample_valid;
    logic [N_CH-1:0] fifo_empty;
    logic [N_CH-1:0] fifo_full;
    logic [N_CH-1:0] fifo_pop;
    logic all_full;
    logic fifo_clr;
    logic run_start;
    logic active;
    logic conv_start;
    conv_period_t conv_period;
    period_t period;

    assign all_full = &fifo_full;  // run ends when every channel is full

    wb_regs u_wb_regs (
        .AD_CLK_40M    (AD_CLK_40M),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .fifo_head_i   (fifo_head),
        .fifo_empty_i  (fifo_empty),
        .all_full_i    (all_full),
        .active_i      (active),
        .period_i      (period),
        .conv_period_o (conv_period),
        .run_start_o   (run_start),
        .fifo_clr_o    (fifo_clr),
        .fifo_pop_o    (fifo_pop)
    );

    conv_timer u_conv_timer (
        .AD_CLK_40M    (AD_CLK_40M),
        .rst_n_i       (rst_n_i),
        .run_start_i   (run_start),
        .all_full_i    (all_full),
        .conv_period_i (conv_period),
        .active_o      (active),
        .conv_start_o  (conv_start)
    );

    ad7606_reader u_reader (
        .AD_CLK_40M     (AD_CLK_40M),
        .rst_n_i        (rst_n_i),
        .conv_start_i   (conv_start),
        .adc_busy_i     (adc_busy_i),
        .adc_db_i       (adc_db_i),
        .adc_convst_n_o (adc_convst_n_o),
        .adc_cs_n_o     (adc_cs_n_o),
        .adc_rd_n_o     (adc_rd_n_o),
        .sample_o       (sample),
        .sample_valid_o (sample_valid)
    );

    // ch0 sits in the top word of the sample struct
    for (genvar i = 0; i < N_CH; i++) begin : g_fifo
        sample_fifo u_fifo (
            .AD_CLK_40M (AD_CLK_40M),
            .rst_n_i    (rst_n_i),
            .clr_i      (fifo_clr),
            .wr_i       (sample_valid),
            .rd_i       (fifo_pop[i]),
            .din_i      (sample[(N_CH-1-i)*ADC_W +: ADC_W]),
            .dout_o     (fifo_head[(N_CH-1-i)*ADC_W +: ADC_W]),
            .empty_o    (fifo_empty[i]),
            .full_o     (fifo_full[i])
        );
    end

    phase_meter u_phase_meter (
        .AD_CLK_40M (AD_CLK_40M),
        .rst_n_i    (rst_n_i),
        .phase_i    (phase_i),
        .period_o   (period)
    );

endmodule

// ==== hdl/wb_regs.sv ====
`timescale 1ns/1ps

module wb_regs (
    input  logic                 AD_CLK_40M,
    input  logic                 rst_n_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  daq_pkg::wb_addr_t    wb_adr_i,
    input  daq_pkg::wb_data_t    wb_dat_i,
    output daq_pkg::wb_data_t    wb_dat_o,
    output logic                 wb_ack_o,
    input  daq_pkg::adc_sample_t fifo_head_i,
    input  logic [daq_pkg::N_CH-1:0] fifo_empty_i,
    input  logic                 all_full_i,
    input  logic                 active_i,
    input  daq_pkg::period_t     period_i,
    output daq_pkg::conv_period_t conv_period_o,
    output logic                 run_start_o,
    output logic                 fifo_clr_o,
    output logic [daq_pkg::N_CH-1:0] fifo_pop_o
);
    import daq_pkg::*;

    logic req;
    logic ack_q;
    wb_data_t dat_q;
    logic [N_CH-1:0] pop_q;
    logic [N_CH-1:0] ch_sel;
    logic enable_q;
    logic enable_d;
    conv_period_t conv_period_q;
    wb_data_t status;
    wb_data_t rd_data;

    assign req = wb_cyc_i & wb_stb_i;

    // --------------------
    // read data
    always_comb begin
        status = '0;
        status[ST_ACTIVE] = active_i;
        status[ST_FULL] = all_full_i;
        status[ST_PHASE_ERR] = (period_i == '0);   // no key phase seen lately
        status[ST_EMPTY_LSB +: N_CH] = fifo_empty_i;
    end

    always_comb begin
        for (int i = 0; i < N_CH; i++) begin
            ch_sel[i] = (wb_adr_i == wb_addr_t'(REG_CH0 + i));
        end
    end

    always_comb begin
        rd_data = '0;                              // unmapped reads give zero
        case (wb_adr_i)
            REG_VERSION:     rd_data = VERSION_ID;
            REG_CONV_PERIOD: rd_data = wb_data_t'(conv_period_q);
            REG_CTRL:        rd_data = wb_data_t'(enable_q);
            REG_STATUS:      rd_data = status;
            REG_PHASE_LO:    rd_data = period_i[15:0];
            REG_PHASE_HI:    rd_data = period_i[31:16];
            REG_CH0:         if (!fifo_empty_i[0]) rd_data = fifo_head_i.ch0;
            REG_CH1:         if (!fifo_empty_i[1]) rd_data = fifo_head_i.ch1;
            REG_CH2:         if (!fifo_empty_i[2]) rd_data = fifo_head_i.ch2;
            REG_CH3:         if (!fifo_empty_i[3]) rd_data = fifo_head_i.ch3;
            default:         rd_data = '0;
        endcase
    end

    // --------------------
    // bus cycle and registers
    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            dat_q <= '0;
            pop_q <= '0;
            enable_q <= 1'b0;
            enable_d <= 1'b0;
            conv_period_q <= CONV_PERIOD_RST;
        end else begin
            ack_q <= req & ~ack_q;                 // one ack, then a gap
            pop_q <= '0;
            enable_d <= enable_q;
            if (req && !ack_q) begin
                if (wb_we_i) begin
                    case (wb_adr_i)
                        REG_CONV_PERIOD: conv_period_q <= conv_period_t'(wb_dat_i);
                        REG_CTRL:        enable_q <= wb_dat_i[0];
                        default:         ;         // read-only or unmapped
                    endcase
                end else begin
                    dat_q <= rd_data;
                    pop_q <= ch_sel & ~fifo_empty_i;   // pop lands in the ack cycle
                end
            end
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = dat_q;
    assign fifo_pop_o = pop_q;
    assign conv_period_o = conv_period_q;

    // enable rising edge clears the FIFOs and kicks off a run
    assign run_start_o = enable_q & ~enable_d;
    assign fifo_clr_o = enable_q & ~enable_d;

endmodule

// ==== hdl/ad7606_reader.sv ====
`timescale 1ns/1ps

module ad7606_reader (
    input  logic                 AD_CLK_40M,
    input  logic                 rst_n_i,
    input  logic                 conv_start_i,
    input  logic                 adc_busy_i,
    input  daq_pkg::adc_word_t   adc_db_i,
    output logic                 adc_convst_n_o,
    output logic                 adc_cs_n_o,
    output logic                 adc_rd_n_o,
    output daq_pkg::adc_sample_t sample_o,
    output logic                 sample_valid_o
);
    import daq_pkg::*;

    rd_state_t state_q;
    rd_state_t state_n;
    logic [RD_CNT_W-1:0] cnt_q;
    logic [CH_IDX_W-1:0] ch_q;
    logic convst_n_q;
    logic rd_n_q;
    logic capture;
    adc_sample_t sample_q;

    // --------------------
    // next state
    always_comb begin
        state_n = state_q;
        case (state_q)
            IDLE: begin
                if (conv_start_i) state_n = CONVST;      // starts while busy are lost
            end
            CONVST: begin
                if (cnt_q == CONVST_CYCLES - 1) state_n = WAIT_BUSY_HI;
            end
            WAIT_BUSY_HI: begin
                if (adc_busy_i) state_n = WAIT_BUSY_LO;
                else if (cnt_q == BUSY_TIMEOUT - 1) state_n = IDLE;
            end
            WAIT_BUSY_LO: begin
                if (!adc_busy_i) state_n = RD_LOW;
                else if (cnt_q == BUSY_TIMEOUT - 1) state_n = IDLE;
            end
            RD_LOW: begin
                if (cnt_q == RD_LOW_CYCLES - 1) state_n = RD_HIGH;
            end
            RD_HIGH: begin
                state_n = (ch_q == CH_IDX_W'(N_CH - 1)) ? DONE : RD_LOW;
            end
            DONE:    state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    assign capture = (state_q == RD_LOW) && (cnt_q == RD_LOW_CYCLES - 1);

    // --------------------
    // state, counters, strobes
    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            cnt_q <= '0;
            ch_q <= '0;
            convst_n_q <= 1'b1;
            rd_n_q <= 1'b1;
        end else begin
            state_q <= state_n;
            cnt_q <= (state_n != state_q) ? '0 : cnt_q + 1'b1;   // per-state time
            if (state_q == IDLE) ch_q <= '0;
            else if (state_q == RD_HIGH && state_n == RD_LOW) ch_q <= ch_q + 1'b1;
            convst_n_q <= (state_n != CONVST);   // strobes follow next state
            rd_n_q <= (state_n != RD_LOW);
        end
    end

    // data bus sampled in the last low cycle
    always_ff @(posedge AD_CLK_40M) begin
        if (capture) begin
            case (ch_q)
                2'd0:    sample_q.ch0 <= adc_db_i;
                2'd1:    sample_q.ch1 <= adc_db_i;
                2'd2:    sample_q.ch2 <= adc_db_i;
                default: sample_q.ch3 <= adc_db_i;
            endcase
        end
    end

    assign adc_convst_n_o = convst_n_q;
    assign adc_cs_n_o = rd_n_q;              // cs_n and rd_n move together
    assign adc_rd_n_o = rd_n_q;
    assign sample_o = sample_q;
    assign sample_valid_o = (state_q == DONE);

endmodule

// ==== hdl/conv_timer.sv ====
`timescale 1ns/1ps

module conv_timer (
    input  logic                  AD_CLK_40M,
    input  logic                  rst_n_i,
    input  logic                  run_start_i,
    input  logic                  all_full_i,
    input  daq_pkg::conv_period_t conv_period_i,
    output logic                  active_o,
    output logic                  conv_start_o
);
    import daq_pkg::*;

    logic active_q;
    conv_period_t cnt_q;
    logic tick;

    // first tick lands conv_period cycles after run_start
    assign tick = active_q && (cnt_q == conv_period_i);

    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            cnt_q <= '0;
        end else begin
            if (run_start_i) begin
                active_q <= 1'b1;
                cnt_q <= conv_period_t'(1);
            end else if (all_full_i) begin
                active_q <= 1'b0;                  // every channel full, stop
            end else if (tick) begin
                cnt_q <= conv_period_t'(1);        // reload
            end else if (active_q) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign active_o = active_q;
    assign conv_start_o = tick;

endmodule

// ==== hdl/phase_meter.sv ====
`timescale 1ns/1ps

module phase_meter (
    input  logic             AD_CLK_40M,
    input  logic             rst_n_i,
    input  logic             phase_i,
    output daq_pkg::period_t period_o
);
    import daq_pkg::*;

    logic [1:0] sync_q;                  // two-flop synchroniser
    logic phase_d;
    logic rise;
    logic seen_q;                        // a first edge has been seen
    period_t cnt_q;
    period_t period_q;

    assign rise = sync_q[1] & ~phase_d;

    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
            phase_d <= 1'b0;
            seen_q <= 1'b0;
            cnt_q <= '0;
            period_q <= '0;
        end else begin
            sync_q <= {sync_q[0], phase_i};
            phase_d <= sync_q[1];
            if (rise) begin
                if (seen_q) period_q <= cnt_q;   // clocks since the last edge
                cnt_q <= period_t'(1);
                seen_q <= 1'b1;
            end else if (seen_q) begin
                if (cnt_q == PHASE_TIMEOUT) begin
                    // key phase lost, restart from the next edge
                    period_q <= '0;
                    seen_q <= 1'b0;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    assign period_o = period_q;

endmodule

// ==== hdl/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo (
    input  logic               AD_CLK_40M,
    input  logic               rst_n_i,
    input  logic               clr_i,
    input  logic               wr_i,
    input  logic               rd_i,
    input  daq_pkg::adc_word_t din_i,
    output daq_pkg::adc_word_t dout_o,
    output logic               empty_o,
    output logic               full_o
);
    import daq_pkg::*;

    adc_word_t mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wptr_q;
    logic [FIFO_PTR_W-1:0] rptr_q;
    fifo_level_t level_q;
    logic wr_en;
    logic rd_en;

    assign full_o = (level_q == FIFO_DEPTH);
    assign empty_o = (level_q == '0);
    assign wr_en = wr_i & ~full_o;           // overflow words are dropped
    assign rd_en = rd_i & ~empty_o;

    always_ff @(posedge AD_CLK_40M) begin
        if (wr_en) mem[wptr_q] <= din_i;
    end

    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wptr_q <= '0;
            rptr_q <= '0;
            level_q <= '0;
        end else if (clr_i) begin
            wptr_q <= '0;
            rptr_q <= '0;
            level_q <= '0;
        end else begin
            if (wr_en) wptr_q <= wptr_q + 1'b1;
            if (rd_en) rptr_q <= rptr_q + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    assign dout_o = mem[rptr_q];             // show-ahead head word

endmodule

// ==== hdl/daq_pkg.sv ====
package daq_pkg;

    // --------------------
    // widths and types
    localparam int ADC_W = 16;
    localparam int N_CH = 4;
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int CH_IDX_W = $clog2(N_CH);

    typedef logic [ADC_W-1:0] adc_word_t;
    typedef logic [3:0] wb_addr_t;             // word address
    typedef logic [15:0] wb_data_t;
    typedef logic [31:0] period_t;             // phase period in clocks
    typedef logic [15:0] conv_period_t;        // clocks between conversions
    typedef logic [FIFO_PTR_W:0] fifo_level_t; // one extra bit for full

    typedef struct packed {
        adc_word_t ch0;                        // top word of the vector
        adc_word_t ch1;
        adc_word_t ch2;
        adc_word_t ch3;
    } adc_sample_t;

    typedef enum logic [2:0] {
        IDLE,
        CONVST,
        WAIT_BUSY_HI,
        WAIT_BUSY_LO,
        RD_LOW,
        RD_HIGH,
        DONE
    } rd_state_t;

    // --------------------
    // constants
    localparam wb_data_t VERSION_ID = 16'h1000;
    localparam conv_period_t CONV_PERIOD_RST = 16'd200;
    localparam int PHASE_TIMEOUT = 4096;
    localparam int CONVST_CYCLES = 2;          // convst_n low time
    localparam int RD_LOW_CYCLES = 2;          // cs_n/rd_n low time per channel
    localparam int BUSY_TIMEOUT = 64;          // limit on each busy wait
    localparam int RD_CNT_W = $clog2(BUSY_TIMEOUT);

    // --------------------
    // register map
    localparam wb_addr_t REG_VERSION = 4'd0;
    localparam wb_addr_t REG_CONV_PERIOD = 4'd1;
    localparam wb_addr_t REG_CTRL = 4'd2;
    localparam wb_addr_t REG_STATUS = 4'd3;
    localparam wb_addr_t REG_PHASE_LO = 4'd4;
    localparam wb_addr_t REG_PHASE_HI = 4'd5;
    localparam wb_addr_t REG_CH0 = 4'd8;
    localparam wb_addr_t REG_CH1 = 4'd9;
    localparam wb_addr_t REG_CH2 = 4'd10;
    localparam wb_addr_t REG_CH3 = 4'd11;

    localparam int ST_ACTIVE = 0;
    localparam int ST_FULL = 1;
    localparam int ST_PHASE_ERR = 2;
    localparam int ST_EMPTY_LSB = 4;           // empty flags in bits 4..7

endpackage
